// File: src/risc8_pkg.sv
// data widths, register and port index types, ALU function enumeration, status bit positions
package risc8_pkg;

	// data path is one byte wide
	localparam int BYTE_W = 8;
	// 32 general registers need a 5-bit index
	localparam int SEL_W = 5;
	// OUT reaches 64 I/O ports
	localparam int PORT_W = 6;

	// number of general registers
	localparam int REG_COUNT = 32;
	// immediate forms only reach r16 to r31
	localparam int LDI_BASE = 16;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [SEL_W-1:0] reg_sel_t;
	typedef logic [PORT_W-1:0] io_port_t;

	// ALU functions, operand A is Rd and operand B is Rr or a constant
	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		EOR,
		// pass operand B through
		MOVR,
		NEG,
		SWAP,
		LSR,
		ROR,
		ASR
	} alu_op_t;

	// status byte layout, same positions as the AVR SREG
	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	// bits 5 to 7 (H, T, I on a full AVR) always read as zero

endpackage

// File: src/risc8_decode.sv
// fetch and decode stage: program counter, opcode decode and registered execute controls
`timescale 1ns/1ps

module risc8_decode #(
	parameter int PC_W = 16
) (
	input logic clk,
	input logic reset,
	input logic [15:0] cdata,
	input logic redirect,
	input logic [PC_W-1:0] redirect_target,
	output logic [PC_W-1:0] pc,
	output risc8_pkg::reg_sel_t sel_a,
	output risc8_pkg::reg_sel_t sel_b,
	output logic ex_valid,
	output risc8_pkg::alu_op_t ex_op,
	output logic ex_carry,
	output logic ex_use_const,
	output risc8_pkg::byte_t ex_const,
	output logic ex_store,
	output risc8_pkg::reg_sel_t ex_dest,
	output logic ex_flags,
	output logic ex_branch,
	output logic [2:0] ex_branch_bit,
	output logic ex_branch_set,
	output logic [PC_W-1:0] ex_branch_target,
	output logic ex_out,
	output risc8_pkg::io_port_t ex_port
);

	// address of the word now on cdata
	logic [PC_W-1:0] op_pc;
	// next arriving word is a wrong-path fetch
	logic bubble;
	logic kill;
	logic jump;

	// opcode fields
	risc8_pkg::reg_sel_t f_rd;
	risc8_pkg::reg_sel_t f_rr;
	risc8_pkg::reg_sel_t f_rdi;
	risc8_pkg::byte_t f_k;
	risc8_pkg::io_port_t f_port;
	logic [15:0] off12;
	logic [15:0] off7;
	logic [PC_W-1:0] rjmp_target;
	logic [PC_W-1:0] br_target;

	// decoded controls before the pipeline register
	risc8_pkg::alu_op_t d_op;
	logic d_carry;
	logic d_use_const;
	risc8_pkg::byte_t d_const;
	logic d_store;
	risc8_pkg::reg_sel_t d_dest;
	logic d_flags;
	logic d_branch;
	logic d_out;
	logic is_rjmp;

	assign f_rd = cdata[8:4];
	assign f_rr = {cdata[9], cdata[3:0]};
	assign f_rdi = risc8_pkg::reg_sel_t'(risc8_pkg::LDI_BASE) | {1'b0, cdata[7:4]};
	assign f_k = {cdata[11:8], cdata[3:0]};
	assign f_port = {cdata[10:9], cdata[3:0]};

	// sign extended jump and branch offsets, targets are pc + k + 1
	assign off12 = {{4{cdata[11]}}, cdata[11:0]};
	assign off7 = {{9{cdata[9]}}, cdata[9:3]};
	assign rjmp_target = op_pc + off12[PC_W-1:0] + PC_W'(1);
	assign br_target = op_pc + off7[PC_W-1:0] + PC_W'(1);

	// a taken branch in execute squashes the word being decoded
	assign kill = redirect | bubble;
	assign jump = is_rjmp & ~kill;

	always_comb begin
		sel_a = f_rd;
		sel_b = f_rr;
		d_op = risc8_pkg::MOVR;
		d_carry = 1'b0;
		d_use_const = 1'b0;
		d_const = f_k;
		d_store = 1'b0;
		d_dest = f_rd;
		d_flags = 1'b0;
		d_branch = 1'b0;
		d_out = 1'b0;
		is_rjmp = 1'b0;

		casez (cdata)
		// two register forms, CP and CPC only set flags
		16'b0000_01??_????_????: begin
			d_op = risc8_pkg::SUB;
			d_carry = 1'b1;
			d_flags = 1'b1;
		end
		16'b0000_10??_????_????: begin
			d_op = risc8_pkg::SUB;
			d_carry = 1'b1;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0000_11??_????_????: begin
			d_op = risc8_pkg::ADD;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0001_01??_????_????: begin
			d_op = risc8_pkg::SUB;
			d_flags = 1'b1;
		end
		16'b0001_10??_????_????: begin
			d_op = risc8_pkg::SUB;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0001_11??_????_????: begin
			d_op = risc8_pkg::ADD;
			d_carry = 1'b1;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0010_00??_????_????: begin
			d_op = risc8_pkg::AND;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0010_01??_????_????: begin
			d_op = risc8_pkg::EOR;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		16'b0010_10??_????_????: begin
			d_op = risc8_pkg::OR;
			d_store = 1'b1;
			d_flags = 1'b1;
		end
		// MOV leaves the flags alone
		16'b0010_11??_????_????: begin
			d_store = 1'b1;
		end
		// immediate forms on r16..r31
		16'b0011_????_????_????,
		16'b0100_????_????_????,
		16'b0101_????_????_????,
		16'b0110_????_????_????,
		16'b0111_????_????_????: begin
			sel_a = f_rdi;
			d_dest = f_rdi;
			d_use_const = 1'b1;
			d_flags = 1'b1;
			// CPI is the only one without a result
			d_store = cdata[15:12] != 4'b0011;
			d_carry = cdata[15:12] == 4'b0100;
			case (cdata[15:12])
			4'b0110: d_op = risc8_pkg::OR;
			4'b0111: d_op = risc8_pkg::AND;
			default: d_op = risc8_pkg::SUB;
			endcase
		end
		// single operand group, flags on all but SWAP
		16'b1001_010?_????_0000,
		16'b1001_010?_????_0001,
		16'b1001_010?_????_0010,
		16'b1001_010?_????_0011,
		16'b1001_010?_????_0101,
		16'b1001_010?_????_0110,
		16'b1001_010?_????_0111,
		16'b1001_010?_????_1010: begin
			d_store = 1'b1;
			d_flags = cdata[3:0] != 4'b0010;
			case (cdata[3:0])
			// COM is Rd xor FF, the EOR with a constant also sets C
			4'b0000: begin
				d_op = risc8_pkg::EOR;
				d_use_const = 1'b1;
				d_const = 8'hff;
			end
			4'b0001: d_op = risc8_pkg::NEG;
			4'b0010: d_op = risc8_pkg::SWAP;
			// INC adds 01 and DEC adds FF, a constant ADD keeps C
			4'b0011: begin
				d_op = risc8_pkg::ADD;
				d_use_const = 1'b1;
				d_const = 8'h01;
			end
			4'b1010: begin
				d_op = risc8_pkg::ADD;
				d_use_const = 1'b1;
				d_const = 8'hff;
			end
			4'b0101: d_op = risc8_pkg::ASR;
			4'b0110: d_op = risc8_pkg::LSR;
			default: d_op = risc8_pkg::ROR;
			endcase
		end
		// OUT sends Rd through operand A
		16'b1011_1???_????_????: begin
			d_out = 1'b1;
		end
		16'b1100_????_????_????: begin
			is_rjmp = 1'b1;
		end
		16'b1110_????_????_????: begin
			d_dest = f_rdi;
			d_use_const = 1'b1;
			d_store = 1'b1;
		end
		// BRBS when bit 10 is clear, BRBC when set
		16'b1111_0???_????_????: begin
			d_branch = 1'b1;
		end
		default: begin
			// anything else runs as a NOP
		end
		endcase
	end

	// fetch pc, a redirect from execute wins over an RJMP here
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			bubble <= 1'b1;
		end else begin
			if (redirect)
				pc <= redirect_target;
			else if (jump)
				pc <= rjmp_target;
			else
				pc <= pc + PC_W'(1);
			bubble <= redirect | jump;
		end
	end

	// memory answers one clock later, so track the word's own address
	always_ff @(posedge clk) begin
		op_pc <= pc;
	end

	// execute enables
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_store <= 1'b0;
			ex_flags <= 1'b0;
			ex_branch <= 1'b0;
			ex_out <= 1'b0;
		end else begin
			ex_valid <= ~kill;
			ex_store <= d_store;
			ex_flags <= d_flags;
			ex_branch <= d_branch;
			ex_out <= d_out;
		end
	end

	// execute payload
	always_ff @(posedge clk) begin
		ex_op <= d_op;
		ex_carry <= d_carry;
		ex_use_const <= d_use_const;
		ex_const <= d_const;
		ex_dest <= d_dest;
		ex_branch_bit <= cdata[2:0];
		ex_branch_set <= ~cdata[10];
		ex_branch_target <= br_target;
		ex_port <= f_port;
	end

endmodule

// File: src/risc8_regfile.sv
// general register file: 32 bytes, two registered read ports with write bypass, one write port
`timescale 1ns/1ps

module risc8_regfile (
	input logic clk,
	input logic reset,
	input risc8_pkg::reg_sel_t sel_a,
	input risc8_pkg::reg_sel_t sel_b,
	output risc8_pkg::byte_t rd_a,
	output risc8_pkg::byte_t rd_b,
	input logic wr_en,
	input risc8_pkg::reg_sel_t wr_sel,
	input risc8_pkg::byte_t wr_data
);

	// flops rather than a RAM, so reset can clear them
	risc8_pkg::byte_t regs [risc8_pkg::REG_COUNT];

	// write port, result of the execute stage
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < risc8_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// read ports sample at the end of decode
	// a write landing on the same edge is forwarded
	always_ff @(posedge clk) begin
		if (wr_en && wr_sel == sel_a)
			rd_a <= wr_data;
		else
			rd_a <= regs[sel_a];

		if (wr_en && wr_sel == sel_b)
			rd_b <= wr_data;
		else
			rd_b <= regs[sel_b];
	end

endmodule

// File: src/risc8_execute.sv
// execute stage: operand select, ALU with AVR flags, status register, write-back, branches, OUT
`timescale 1ns/1ps

module risc8_execute #(
	parameter int PC_W = 16
) (
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input risc8_pkg::alu_op_t ex_op,
	input logic ex_carry,
	input logic ex_use_const,
	input risc8_pkg::byte_t ex_const,
	input logic ex_store,
	input risc8_pkg::reg_sel_t ex_dest,
	input logic ex_flags,
	input logic ex_branch,
	input logic [2:0] ex_branch_bit,
	input logic ex_branch_set,
	input logic [PC_W-1:0] ex_branch_target,
	input logic ex_out,
	input risc8_pkg::io_port_t ex_port,
	input risc8_pkg::byte_t rd_a,
	input risc8_pkg::byte_t rd_b,
	output logic wr_en,
	output risc8_pkg::reg_sel_t wr_sel,
	output risc8_pkg::byte_t wr_data,
	output logic redirect,
	output logic [PC_W-1:0] redirect_target,
	output logic io_wen,
	output risc8_pkg::io_port_t io_port,
	output risc8_pkg::byte_t io_wdata
);

	risc8_pkg::byte_t opb;
	risc8_pkg::byte_t res;
	risc8_pkg::byte_t sreg;
	risc8_pkg::byte_t sreg_next;
	logic [8:0] wide;
	logic cin;
	logic c;
	logic v;
	// SBC, SBCI and CPC chain Z over multi-byte compares
	logic z_chain;

	assign opb = ex_use_const ? ex_const : rd_b;
	assign cin = ex_carry & sreg[risc8_pkg::SREG_C];

	always_comb begin
		wide = '0;
		res = opb;
		c = sreg[risc8_pkg::SREG_C];
		v = 1'b0;
		z_chain = 1'b0;
		case (ex_op)
		risc8_pkg::ADD: begin
			wide = {1'b0, rd_a} + {1'b0, opb} + {8'd0, cin};
			res = wide[7:0];
			// INC and DEC are the only constant adds and keep C
			if (!ex_use_const)
				c = wide[8];
			v = (rd_a[7] & opb[7] & ~res[7]) | (~rd_a[7] & ~opb[7] & res[7]);
		end
		risc8_pkg::SUB: begin
			wide = {1'b0, rd_a} - {1'b0, opb} - {8'd0, cin};
			res = wide[7:0];
			c = wide[8];
			v = (rd_a[7] & ~opb[7] & ~res[7]) | (~rd_a[7] & opb[7] & res[7]);
			z_chain = ex_carry;
		end
		risc8_pkg::AND: res = rd_a & opb;
		risc8_pkg::OR: res = rd_a | opb;
		risc8_pkg::EOR: begin
			res = rd_a ^ opb;
			// COM sets carry
			if (ex_use_const)
				c = 1'b1;
		end
		risc8_pkg::MOVR: res = opb;
		risc8_pkg::NEG: begin
			wide = 9'd0 - {1'b0, rd_a};
			res = wide[7:0];
			c = res != 8'h00;
			v = res == 8'h80;
		end
		risc8_pkg::SWAP: res = {rd_a[3:0], rd_a[7:4]};
		// shifts put bit 0 in C, V is N xor C
		risc8_pkg::LSR: begin
			res = {1'b0, rd_a[7:1]};
			c = rd_a[0];
			v = res[7] ^ rd_a[0];
		end
		risc8_pkg::ROR: begin
			res = {sreg[risc8_pkg::SREG_C], rd_a[7:1]};
			c = rd_a[0];
			v = res[7] ^ rd_a[0];
		end
		risc8_pkg::ASR: begin
			res = {rd_a[7], rd_a[7:1]};
			c = rd_a[0];
			v = res[7] ^ rd_a[0];
		end
		default: res = opb;
		endcase
	end

	// new status byte, top three bits stay zero
	always_comb begin
		sreg_next = '0;
		sreg_next[risc8_pkg::SREG_C] = c;
		sreg_next[risc8_pkg::SREG_Z] = (res == 8'h00) & (~z_chain | sreg[risc8_pkg::SREG_Z]);
		sreg_next[risc8_pkg::SREG_N] = res[7];
		sreg_next[risc8_pkg::SREG_V] = v;
		sreg_next[risc8_pkg::SREG_S] = res[7] ^ v;
	end

	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else if (ex_valid && ex_flags)
			sreg <= sreg_next;
	end

	// write-back lands at the end of this cycle
	assign wr_en = ex_valid & ex_store;
	assign wr_sel = ex_dest;
	assign wr_data = res;

	// branch tests the flags as they were before this cycle
	assign redirect = ex_valid & ex_branch & (sreg[ex_branch_bit] == ex_branch_set);
	assign redirect_target = ex_branch_target;

	// port write strobe, one cycle
	always_ff @(posedge clk) begin
		if (reset)
			io_wen <= 1'b0;
		else
			io_wen <= ex_valid & ex_out;
	end

	always_ff @(posedge clk) begin
		io_port <= ex_port;
		io_wdata <= rd_a;
	end

endmodule

// File: src/risc8_core.sv
// core top level: decode, register file and execute stages wired together
`timescale 1ns/1ps

module risc8_core #(
	parameter int PC_W = 16
) (
	input logic clk,
	input logic reset,
	output logic [PC_W-1:0] pc,
	input logic [15:0] cdata,
	output logic io_wen,
	output risc8_pkg::io_port_t io_port,
	output risc8_pkg::byte_t io_wdata
);

	// register read addresses and data
	risc8_pkg::reg_sel_t sel_a;
	risc8_pkg::reg_sel_t sel_b;
	risc8_pkg::byte_t rd_a;
	risc8_pkg::byte_t rd_b;

	// decode to execute
	logic ex_valid;
	risc8_pkg::alu_op_t ex_op;
	logic ex_carry;
	logic ex_use_const;
	risc8_pkg::byte_t ex_const;
	logic ex_store;
	risc8_pkg::reg_sel_t ex_dest;
	logic ex_flags;
	logic ex_branch;
	logic [2:0] ex_branch_bit;
	logic ex_branch_set;
	logic [PC_W-1:0] ex_branch_target;
	logic ex_out;
	risc8_pkg::io_port_t ex_port;

	// write-back and branch redirect
	logic wr_en;
	risc8_pkg::reg_sel_t wr_sel;
	risc8_pkg::byte_t wr_data;
	logic redirect;
	logic [PC_W-1:0] redirect_target;

	risc8_decode #(
		.PC_W(PC_W)
	) i_decode (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.pc(pc),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_carry(ex_carry),
		.ex_use_const(ex_use_const),
		.ex_const(ex_const),
		.ex_store(ex_store),
		.ex_dest(ex_dest),
		.ex_flags(ex_flags),
		.ex_branch(ex_branch),
		.ex_branch_bit(ex_branch_bit),
		.ex_branch_set(ex_branch_set),
		.ex_branch_target(ex_branch_target),
		.ex_out(ex_out),
		.ex_port(ex_port)
	);

	risc8_regfile i_regfile (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data)
	);

	risc8_execute #(
		.PC_W(PC_W)
	) i_execute (
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_op(ex_op),
		.ex_carry(ex_carry),
		.ex_use_const(ex_use_const),
		.ex_const(ex_const),
		.ex_store(ex_store),
		.ex_dest(ex_dest),
		.ex_flags(ex_flags),
		.ex_branch(ex_branch),
		.ex_branch_bit(ex_branch_bit),
		.ex_branch_set(ex_branch_set),
		.ex_branch_target(ex_branch_target),
		.ex_out(ex_out),
		.ex_port(ex_port),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_data(wr_data),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.io_wen(io_wen),
		.io_port(io_port),
		.io_wdata(io_wdata)
	);

endmodule

// File: sim/risc8_clkgen.sv
// testbench clock and reset generator: 100 ns clock, reset held for three cycles
`timescale 1ns/1ps

module risc8_clkgen (
	output logic clk,
	output logic reset
);

	// half of the 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// release reset a little after the third rising edge
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#10 reset = 1'b0;
	end

endmodule

// File: sim/risc8_core_assert.sv
// bound assertions on the core outputs: reset behavior of io_wen and pc, known port data
`timescale 1ns/1ps

module risc8_core_assert #(
	parameter int PC_W = 16
) (
	input logic clk,
	input logic reset,
	input logic [PC_W-1:0] pc,
	input logic io_wen,
	input risc8_pkg::io_port_t io_port,
	input risc8_pkg::byte_t io_wdata
);

	// no port write while reset is applied
	wen_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !io_wen)
		else $error("io_wen high during reset");

	// nor in the first cycle once reset is gone
	wen_low_after_reset: assert property (@(posedge clk) $past(reset, 2) |-> !io_wen)
		else $error("io_wen high right after reset");

	// a write strobe always carries a defined port and byte
	write_known: assert property (@(posedge clk) io_wen |-> !$isunknown({io_port, io_wdata}))
		else $error("io_port or io_wdata unknown during a write");

	// fetch starts at address zero
	pc_zero_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == '0)
		else $error("pc not zero after reset");

endmodule

bind risc8_core risc8_core_assert #(
	.PC_W(PC_W)
) i_core_assert (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.io_wen(io_wen),
	.io_port(io_port),
	.io_wdata(io_wdata)
);

// File: sim/risc8_tb.sv
// testbench top: program memory model, stim file loader, OUT write checker and timeouts
`timescale 1ns/1ps

module risc8_tb;

	localparam int PC_W = 16;
	localparam int MEM_DEPTH = 1024;
	// cycles allowed between two expected port writes
	localparam int WRITE_TIMEOUT = 200;
	localparam int RESET_TIMEOUT = 20;
	// quiet cycles after the last expected write
	localparam int IDLE_CYCLES = 20;
	// input drive delay after the rising edge
	localparam int DRIVE_DELAY = 10;

	logic clk;
	logic reset;
	logic [PC_W-1:0] pc;
	logic [15:0] cdata;
	logic io_wen;
	risc8_pkg::io_port_t io_port;
	risc8_pkg::byte_t io_wdata;

	// program memory and expected OUT writes, filled from the stim file
	logic [15:0] prog [MEM_DEPTH];
	risc8_pkg::io_port_t exp_port [$];
	risc8_pkg::byte_t exp_data [$];
	logic [15:0] fetch_word;

	risc8_clkgen i_clkgen (
		.clk(clk),
		.reset(reset)
	);

	risc8_core #(
		.PC_W(PC_W)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.io_wen(io_wen),
		.io_port(io_port),
		.io_wdata(io_wdata)
	);

	initial cdata = 16'h0000;

	// synchronous read, pc is sampled before the core updates it on this edge
	always @(posedge clk) begin
		if ($isunknown(pc))
			fetch_word = 16'h0000;
		else
			fetch_word = prog[pc[9:0]];
		#DRIVE_DELAY;
		cdata = fetch_word;
	end

	// P lines carry an address and four words, E lines one expected write
	task automatic load_stim();
		int fd;
		int n;
		string line;
		logic [31:0] addr;
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		// empty memory decodes as NOP
		for (int i = 0; i < MEM_DEPTH; i++)
			prog[i] = 16'h0000;
		fd = $fopen("sim/risc8_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file sim/risc8_stim.txt");
			$display("SOME TESTS FAILED");
			$fatal(1, "missing stimulus file");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "P %h %h %h %h %h", addr, w0, w1, w2, w3);
			if (n == 5) begin
				prog[addr[9:0]] = w0[15:0];
				prog[addr[9:0] + 10'd1] = w1[15:0];
				prog[addr[9:0] + 10'd2] = w2[15:0];
				prog[addr[9:0] + 10'd3] = w3[15:0];
			end else begin
				n = $sscanf(line, "E %h %h", addr, w0);
				if (n == 2) begin
					exp_port.push_back(addr[5:0]);
					exp_data.push_back(w0[7:0]);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic check_port(input risc8_pkg::io_port_t got, input risc8_pkg::io_port_t exp,
		input int idx);
		if (got !== exp) begin
			$display("Error at %0t ns: write %0d went to port %h, expected port %h",
				$time, idx, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "port mismatch");
		end
	endtask

	task automatic check_data(input risc8_pkg::byte_t got, input risc8_pkg::byte_t exp,
		input int idx);
		if (got !== exp) begin
			$display("Error at %0t ns: write %0d carried data %h, expected %h",
				$time, idx, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic wait_reset_release();
		int count;
		count = 0;
		while (reset === 1'b1) begin
			@(negedge clk);
			count++;
			if (count > RESET_TIMEOUT) begin
				$display("reset was never released");
				$display("SOME TESTS FAILED");
				$fatal(1, "reset timeout");
			end
		end
	endtask

	// outputs are read at the falling edge, half a cycle after they change
	task automatic wait_write(input int idx);
		int count;
		count = 0;
		@(negedge clk);
		while (io_wen !== 1'b1) begin
			count++;
			if (count > WRITE_TIMEOUT) begin
				$display("expected write %0d to port %h with data %h never came",
					idx, exp_port[idx], exp_data[idx]);
				$display("SOME TESTS FAILED");
				$fatal(1, "write timeout");
			end
			@(negedge clk);
		end
		check_port(io_port, exp_port[idx], idx);
		check_data(io_wdata, exp_data[idx], idx);
	endtask

	// program now spins on its last RJMP, nothing more may be written
	task automatic check_idle();
		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk);
			if (io_wen === 1'b1) begin
				$display("Error at %0t ns: extra write to port %h with data %h",
					$time, io_port, io_wdata);
				$display("SOME TESTS FAILED");
				$fatal(1, "unexpected write");
			end
		end
	endtask

	initial begin
		load_stim();
		if (exp_port.size() == 0) begin
			$display("the stimulus file lists no expected writes");
			$display("SOME TESTS FAILED");
			$fatal(1, "empty expectation list");
		end
		wait_reset_release();
		for (int i = 0; i < exp_port.size(); i++)
			wait_write(i);
		check_idle();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: all.f
src/risc8_pkg.sv
src/risc8_decode.sv
src/risc8_regfile.sv
src/risc8_execute.sv
src/risc8_core.sv
sim/risc8_clkgen.sv
sim/risc8_core_assert.sv
sim/risc8_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module risc8_tb \
	--Mdir obj_dir -o risc8_sim \
	-f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/risc8_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi

exit 0

// File: sim/risc8_stim.txt
// P <addr> <word> <word> <word> <word> : four program words from addr on, hex
// E <port> <data> : next expected OUT write, hex, in program order
P 0000 E50A EC13 B901 BD12
P 0004 0F01 1F01 1B01 0B01
P 0008 2301 2B01 2710 2F21
P 000C B902 B923 E130 5230
P 0010 4031 6031 773F B934
P 0014 9530 9531 9533 953A
P 0018 B935 9536 9537 9532
P 001C 9535 9537 B936 E045
P 0020 E055 1745 F009 BF40
P 0024 F408 BF40 F008 B947
P 0028 3046 F40A B958 F00C
P 002C BF40 F00B B949 E860
P 0030 3061 F00B BF40 1745
P 0034 0754 F409 B96A E073
P 0038 B97B 957A F7E9 C001
P 003C BF40 9508 0000 FFFF
P 0040 B90C CFFF 0000 0000
E 01 5A
E 22 C3
E 02 C3
E 03 00
E 04 6F
E 05 70
E 06 F0
E 07 05
E 08 05
E 09 05
E 0A 80
E 0B 03
E 0B 02
E 0B 01
E 0C C3
